/* verilog/kbd_vga_settings.svh */
`ifndef KBD_VGA_SETTINGS_SVH
`define KBD_VGA_SETTINGS_SVH

// horizontal timing, pixels per line
`define H_ACTIVE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_BACK 48
`define H_TOTAL (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)

// vertical timing, lines per frame
// both syncs are active low
`define V_ACTIVE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_BACK 33
`define V_TOTAL (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)

// top-left corner of key Q
`define KB_X 80
`define KB_Y 120

// key square and spacing
`define KEY_W 40
`define KEY_H 40
`define KEY_PITCH 50
`define ROW_STEP 60

// x offset of rows A..J and Z..M
`define ROW1_SHIFT 30
`define ROW2_SHIFT 40

`define KEYS_PER_ROW 7
`define NUM_KEYS 21

// glyph box in the top-left of each key
`define GLYPH_W 16
`define GLYPH_H 32

// letter bitmap, 32 rows of 16 bits, row 0 in the top word
`define GLYPH_BITS { \
    64'h0000_0000_0000_0180, \
    64'h03C0_03C0_0660_0660, \
    64'h0C30_0C30_0C30_1818, \
    64'h1818_1818_300C_300C, \
    64'h3FFC_3FFC_6006_6006, \
    64'h6006_C003_C003_C003, \
    64'hC003_C003_0000_0000, \
    64'h0000_0000_0000_0000}

// 4 bits each of red, green, blue
`define COLOR_BG 12'h0F0
`define COLOR_IDLE 12'hFFF
`define COLOR_LIT 12'hFF0
`define COLOR_INK 12'h000

`endif

/* verilog/video_pkg.sv */
package video_pkg;

    // pixel or line count, covers 0..799
    typedef logic [9:0] coord_t;

    // one pixel, red in the top nibble
    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } color_t;

    // where a counter sits within its line or frame
    typedef enum logic [1:0] {
        ph_active,
        ph_front,
        ph_sync,
        ph_back
    } scan_phase_t;

endpackage

/* verilog/keyboard_pkg.sv */
package keyboard_pkg;

    // row * 7 + column, Q..U then A..J then Z..M
    typedef logic [4:0] key_code_t;

    // toggled by each press of the key
    typedef enum logic {
        key_idle,
        key_lit
    } key_state_t;

    // one flag per key, bit n for code n
    typedef logic [20:0] key_mask_t;

    // offset inside the 16x32 glyph box
    typedef struct packed {
        logic [4:0] row;
        logic [3:0] col;
    } glyph_off_t;

endpackage

/* verilog/vga_timing.sv */
`timescale 1ns/100ps

`include "kbd_vga_settings.svh"

module vga_timing import video_pkg::*; (
    input  logic   vga_clk,
    input  logic   rst,
    output coord_t pix_x,
    output coord_t pix_y,
    output logic   video_on,
    output logic   hsync,
    output logic   vsync
);

    coord_t      h_cnt;
    coord_t      v_cnt;
    scan_phase_t h_phase;
    scan_phase_t v_phase;
    logic        h_last;
    logic        v_last;

    // same region split for both axes
    function automatic scan_phase_t phase_of(
        input coord_t cnt,
        input int     active,
        input int     front,
        input int     sync
    );
        if (cnt < active) begin
            return ph_active;
        end else if (cnt < active + front) begin
            return ph_front;
        end else if (cnt < active + front + sync) begin
            return ph_sync;
        end
        return ph_back;
    endfunction

    assign h_last = (h_cnt == `H_TOTAL - 1);
    assign v_last = (v_cnt == `V_TOTAL - 1);

    // pixel counter, line counter steps on pixel wrap
    always_ff @(posedge vga_clk or negedge rst) begin
        if (!rst) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_last) begin
            h_cnt <= '0;
            if (v_last) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    always_comb begin
        h_phase = phase_of(h_cnt, `H_ACTIVE, `H_FRONT, `H_SYNC);
        v_phase = phase_of(v_cnt, `V_ACTIVE, `V_FRONT, `V_SYNC);
    end

    // coordinate of the pixel being computed this cycle
    assign pix_x    = h_cnt;
    assign pix_y    = v_cnt;
    assign video_on = (h_phase == ph_active) && (v_phase == ph_active);

    // one stage late, in step with the registered colour
    always_ff @(posedge vga_clk or negedge rst) begin
        if (!rst) begin
            hsync <= 1'b1;
            vsync <= 1'b1;
        end else begin
            hsync <= (h_phase != ph_sync);
            vsync <= (v_phase != ph_sync);
        end
    end

endmodule

/* verilog/key_locator.sv */
`timescale 1ns/100ps

`include "kbd_vga_settings.svh"

module key_locator import video_pkg::*; import keyboard_pkg::*; (
    input  coord_t     pix_x,
    input  coord_t     pix_y,
    output logic       key_hit,
    output key_code_t  hit_code,
    output glyph_off_t glyph_off,
    output logic       in_glyph
);

    logic       row_hit;
    logic [1:0] row_idx;
    coord_t     row_top;
    logic       col_hit;
    logic [2:0] col_idx;
    coord_t     key_left;
    coord_t     off_x;
    coord_t     off_y;

    // lower rows are staggered to the right
    function automatic coord_t row_shift(input logic [1:0] row);
        case (row)
            2'd1:    return coord_t'(`ROW1_SHIFT);
            2'd2:    return coord_t'(`ROW2_SHIFT);
            default: return '0;
        endcase
    endfunction

    // row band search on y
    always_comb begin
        row_hit = 1'b0;
        row_idx = '0;
        row_top = '0;
        for (int r = 0; r < `NUM_KEYS / `KEYS_PER_ROW; r++) begin
            if (pix_y >= `KB_Y + r * `ROW_STEP && pix_y < `KB_Y + r * `ROW_STEP + `KEY_H) begin
                row_hit = 1'b1;
                row_idx = 2'(r);
                row_top = coord_t'(`KB_Y + r * `ROW_STEP);
            end
        end
    end

    // column search on x, only inside the matched row
    always_comb begin : col_search
        coord_t col_left;
        col_hit  = 1'b0;
        col_idx  = '0;
        key_left = '0;
        for (int c = 0; c < `KEYS_PER_ROW; c++) begin
            col_left = coord_t'(`KB_X + row_shift(row_idx) + c * `KEY_PITCH);
            if (pix_x >= col_left && pix_x < col_left + `KEY_W) begin
                col_hit  = 1'b1;
                col_idx  = 3'(c);
                key_left = col_left;
            end
        end
    end

    // keys never overlap, so at most one match
    assign key_hit  = row_hit && col_hit;
    assign hit_code = key_hit ? key_code_t'(row_idx * `KEYS_PER_ROW + col_idx) : '0;

    // offset from the key's top-left corner
    assign off_x = pix_x - key_left;
    assign off_y = pix_y - row_top;

    assign glyph_off.row = off_y[4:0];
    assign glyph_off.col = off_x[3:0];
    assign in_glyph      = key_hit && (off_x < `GLYPH_W) && (off_y < `GLYPH_H);

endmodule

/* verilog/key_painter.sv */
`timescale 1ns/100ps

`include "kbd_vga_settings.svh"

module key_painter import video_pkg::*; import keyboard_pkg::*; (
    input  logic       vga_clk,
    input  logic       rst,
    input  logic       video_on,
    input  logic       key_hit,
    input  logic       in_glyph,
    input  key_code_t  hit_code,
    input  glyph_off_t glyph_off,
    input  logic       key_press,
    input  key_code_t  key_code,
    output color_t     pix_color
);

    // msb first, row-major
    localparam logic [511:0] glyph_bits = `GLYPH_BITS;

    key_state_t key_state [`NUM_KEYS];
    key_mask_t  press_mask;
    key_mask_t  lit_mask;
    logic [8:0] glyph_idx;
    logic       glyph_ink;

    // out-of-range codes decode to no key at all
    always_comb begin
        press_mask = '0;
        if (key_press && key_code < `NUM_KEYS) begin
            press_mask = key_mask_t'(1) << key_code;
        end
    end

    // every press flips its key, nothing is ever held off
    always_ff @(posedge vga_clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < `NUM_KEYS; i++) begin
                key_state[i] <= key_idle;
            end
        end else begin
            for (int i = 0; i < `NUM_KEYS; i++) begin
                if (press_mask[i]) begin
                    key_state[i] <= (key_state[i] == key_lit) ? key_idle : key_lit;
                end
            end
        end
    end

    // flat view of the states for indexing by hit code
    always_comb begin
        for (int i = 0; i < `NUM_KEYS; i++) begin
            lit_mask[i] = (key_state[i] == key_lit);
        end
    end

    // row * 16 + col
    assign glyph_idx = {glyph_off.row, glyph_off.col};
    assign glyph_ink = in_glyph && glyph_bits[9'd511 - glyph_idx];

    // blanking, then glyph ink, then key face, then background
    always_ff @(posedge vga_clk or negedge rst) begin
        if (!rst) begin
            pix_color <= `COLOR_INK;
        end else if (!video_on) begin
            pix_color <= `COLOR_INK;
        end else if (glyph_ink) begin
            pix_color <= `COLOR_INK;
        end else if (key_hit) begin
            pix_color <= lit_mask[hit_code] ? `COLOR_LIT : `COLOR_IDLE;
        end else begin
            pix_color <= `COLOR_BG;
        end
    end

endmodule

/* verilog/keyboard_display.sv */
`timescale 1ns/100ps

`include "kbd_vga_settings.svh"

module keyboard_display import video_pkg::*; import keyboard_pkg::*; (
    input  logic      vga_clk,
    input  logic      rst,
    input  logic      key_press,
    input  key_code_t key_code,
    output logic      hsync,
    output logic      vsync,
    output logic [3:0] red,
    output logic [3:0] green,
    output logic [3:0] blue
);

    coord_t     pix_x;
    coord_t     pix_y;
    logic       video_on;
    logic       key_hit;
    logic       in_glyph;
    key_code_t  hit_code;
    glyph_off_t glyph_off;
    color_t     pix_color;

    // counters and syncs
    vga_timing i_vga_timing (
        .vga_clk  (vga_clk),
        .rst      (rst),
        .pix_x    (pix_x),
        .pix_y    (pix_y),
        .video_on (video_on),
        .hsync    (hsync),
        .vsync    (vsync)
    );

    // which key, if any, lies under the pixel
    key_locator i_key_locator (
        .pix_x     (pix_x),
        .pix_y     (pix_y),
        .key_hit   (key_hit),
        .hit_code  (hit_code),
        .glyph_off (glyph_off),
        .in_glyph  (in_glyph)
    );

    // key states and the registered pixel colour
    key_painter i_key_painter (
        .vga_clk   (vga_clk),
        .rst       (rst),
        .video_on  (video_on),
        .key_hit   (key_hit),
        .in_glyph  (in_glyph),
        .hit_code  (hit_code),
        .glyph_off (glyph_off),
        .key_press (key_press),
        .key_code  (key_code),
        .pix_color (pix_color)
    );

    assign red   = pix_color.red;
    assign green = pix_color.green;
    assign blue  = pix_color.blue;

endmodule

/* verification/keyboard_display_assert.sv */
`timescale 1ns/100ps

`include "kbd_vga_settings.svh"

module keyboard_display_assert import video_pkg::*; (
    input logic   vga_clk,
    input logic   rst,
    input coord_t h_cnt,
    input logic   hsync,
    input logic   vsync
);

    int low_run;

    // length of the current hsync pulse
    always_ff @(posedge vga_clk or negedge rst) begin
        if (!rst) begin
            low_run <= 0;
        end else if (!hsync) begin
            low_run <= low_run + 1;
        end else begin
            low_run <= 0;
        end
    end

    hsync_width: assert property (@(posedge vga_clk) disable iff (!rst)
        $rose(hsync) |-> low_run == `H_SYNC)
        else $error("hsync pulse is not %0d cycles", `H_SYNC);

    h_cnt_range: assert property (@(posedge vga_clk) disable iff (!rst)
        h_cnt <= `H_TOTAL - 1)
        else $error("horizontal counter past line end");

    // vsync is one stage behind the counter, so it moves one pixel after wrap
    vsync_at_wrap: assert property (@(posedge vga_clk) disable iff (!rst)
        $changed(vsync) |-> h_cnt == 1)
        else $error("vsync changed away from a line wrap");

endmodule

bind vga_timing keyboard_display_assert i_keyboard_display_assert (
    .vga_clk (vga_clk),
    .rst     (rst),
    .h_cnt   (h_cnt),
    .hsync   (hsync),
    .vsync   (vsync)
);

/* verification/keyboard_display_tb.sv */
`timescale 1ns/100ps

`include "kbd_vga_settings.svh"

module keyboard_display_tb import video_pkg::*; import keyboard_pkg::*; ;

    localparam int frame_cycles = `H_TOTAL * `V_TOTAL;
    // three frames plus some slack
    localparam int cycle_limit = 3 * frame_cycles + 10000;
    localparam logic [511:0] glyph_ref = `GLYPH_BITS;

    logic      vga_clk;
    logic      rst;
    logic      key_press;
    key_code_t key_code;
    logic      hsync;
    logic      vsync;
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;

    int  cycles;
    bit  aligned;
    int  sx;
    int  sy;

    keyboard_display i_keyboard_display (
        .vga_clk   (vga_clk),
        .rst       (rst),
        .key_press (key_press),
        .key_code  (key_code),
        .hsync     (hsync),
        .vsync     (vsync),
        .red       (red),
        .green     (green),
        .blue      (blue)
    );

    // 8 ns period
    initial vga_clk = 1'b0;
    always #4 vga_clk = ~vga_clk;

    // run limit
    always @(posedge vga_clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: no result after %0d cycles", cycles);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    end

    // model of the pixel shown on the outputs
    // locks on the first vsync fall, which shows (0, 490)
    always @(negedge vga_clk) begin
        if (!aligned) begin
            if (rst && vsync === 1'b0) begin
                aligned = 1'b1;
                sx = 0;
                sy = `V_ACTIVE + `V_FRONT;
            end
        end else begin
            sx++;
            if (sx == `H_TOTAL) begin
                sx = 0;
                sy = (sy == `V_TOTAL - 1) ? 0 : sy + 1;
            end
        end
    end

    function automatic color_t shown_color();
        return color_t'({red, green, blue});
    endfunction

    // key geometry from the layout rule
    function automatic int left_of(input int code);
        int row;
        int shift;
        row = code / `KEYS_PER_ROW;
        shift = (row == 1) ? `ROW1_SHIFT : (row == 2) ? `ROW2_SHIFT : 0;
        return `KB_X + shift + (code % `KEYS_PER_ROW) * `KEY_PITCH;
    endfunction

    function automatic int top_of(input int code);
        return `KB_Y + (code / `KEYS_PER_ROW) * `ROW_STEP;
    endfunction

    // ink where the bitmap bit is set, key face elsewhere
    function automatic color_t glyph_color(input int gr, input int gc);
        return glyph_ref[511 - (gr * `GLYPH_W + gc)] ? `COLOR_INK : `COLOR_IDLE;
    endfunction

    task automatic step();
        @(negedge vga_clk);
        #1;
    endtask

    // wait until the outputs show pixel (x, y)
    task automatic goto(input int x, input int y);
        do begin
            step();
        end while (!(aligned && sx == x && sy == y));
    endtask

    task automatic press(input key_code_t code);
        @(posedge vga_clk);
        #1;
        key_press = 1'b1;
        key_code  = code;
        @(posedge vga_clk);
        #1;
        key_press = 1'b0;
        key_code  = '0;
    endtask

    task automatic check_color(input string name, input color_t exp, input color_t act);
        if (exp !== act) begin
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_sync(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("mismatch %s: expected %b, actual %b", name, exp, act);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    task automatic test_reset();
        repeat (2) @(posedge vga_clk);
        #1;
        check_sync("reset hsync", 1'b1, hsync);
        check_sync("reset vsync", 1'b1, vsync);
        check_color("reset colour", `COLOR_INK, shown_color());
        repeat (3) @(posedge vga_clk);
        #1;
        rst = 1'b1;
        // before the first edge out of reset
        #1;
        check_sync("after reset hsync", 1'b1, hsync);
        check_sync("after reset vsync", 1'b1, vsync);
        check_color("after reset colour", `COLOR_INK, shown_color());
    endtask

    task automatic test_sync_timing();
        int n;
        int fall_at;
        do begin
            step();
        end while (!aligned);
        fall_at = cycles;
        // vsync pulse width in cycles
        n = 0;
        while (vsync === 1'b0) begin
            n++;
            step();
        end
        check_count("vsync low cycles", `V_SYNC * `H_TOTAL, n);
        while (hsync !== 1'b0) begin
            step();
        end
        n = 0;
        while (hsync === 1'b0) begin
            n++;
            step();
        end
        check_count("hsync low cycles", `H_SYNC, n);
        // continue counting up to the next fall
        while (hsync !== 1'b0) begin
            n++;
            step();
        end
        check_count("hsync period", `H_TOTAL, n);
        while (vsync !== 1'b0) begin
            step();
        end
        check_count("vsync period", frame_cycles, cycles - fall_at);
    endtask

    task automatic test_blanking_and_background();
        // vertical blanking, then the top of the next frame
        goto(10, 500);
        check_color("blank line 500", `COLOR_INK, shown_color());
        goto(700, 524);
        check_color("blank line 524", `COLOR_INK, shown_color());
        goto(10, 10);
        check_color("background 10,10", `COLOR_BG, shown_color());
        check_sync("hsync in active", 1'b1, hsync);
        check_sync("vsync in active", 1'b1, vsync);
        goto(300, 50);
        check_color("background 300,50", `COLOR_BG, shown_color());
        goto(700, 60);
        check_color("hblank 700,60", `COLOR_INK, shown_color());
        check_sync("hsync pulse", 1'b0, hsync);
        goto(639, 119);
        check_color("background 639,119", `COLOR_BG, shown_color());
    endtask

    task automatic test_key_layout_and_glyph();
        int code;
        int gr;
        int x0;
        int y0;
        // one random key per row, rows come in scan order
        for (int row = 0; row < 3; row++) begin
            code = row * `KEYS_PER_ROW + int'($urandom % `KEYS_PER_ROW);
            gr = int'($urandom % `GLYPH_H);
            x0 = left_of(code);
            y0 = top_of(code);
            for (int gc = 0; gc < `GLYPH_W; gc++) begin
                goto(x0 + gc, y0 + gr);
                check_color($sformatf("key %0d glyph %0d,%0d", code, gr, gc),
                            glyph_color(gr, gc), shown_color());
            end
            goto(x0 + 5, y0 + 35);
            check_color($sformatf("key %0d face", code), `COLOR_IDLE, shown_color());
            goto(x0 + `KEY_W, y0 + 35);
            check_color($sformatf("key %0d right edge", code), `COLOR_BG, shown_color());
        end
    endtask

    task automatic test_key_press();
        int code;
        int nb;
        int y0;
        // bottom row, below the glyph box
        code = 2 * `KEYS_PER_ROW + int'($urandom % `KEYS_PER_ROW);
        nb = (code % `KEYS_PER_ROW < `KEYS_PER_ROW - 1) ? code + 1 : code - 1;
        y0 = top_of(code);
        goto(600, y0 + 35);
        press(key_code_t'(code));
        goto(left_of(code) + 5, y0 + 36);
        check_color($sformatf("press key %0d", code), `COLOR_LIT, shown_color());
        goto(left_of(nb) + 5, y0 + 37);
        check_color($sformatf("neighbour key %0d", nb), `COLOR_IDLE, shown_color());
        goto(600, y0 + 37);
        press(key_code_t'(code));
        goto(left_of(code) + 5, y0 + 38);
        check_color($sformatf("second press key %0d", code), `COLOR_IDLE, shown_color());
        // out of range code
        goto(600, y0 + 38);
        press(key_code_t'(25));
        goto(left_of(code) + 5, y0 + 39);
        check_color("press code 25", `COLOR_IDLE, shown_color());
    endtask

    initial begin
        int seed_ret;
        seed_ret = $urandom(32'h8ce15aa3);
        rst = 1'b0;
        key_press = 1'b0;
        key_code = '0;
        cycles = 0;
        aligned = 1'b0;
        sx = 0;
        sy = 0;
        test_reset();
        test_sync_timing();
        test_blanking_and_background();
        test_key_layout_and_glyph();
        test_key_press();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* sim.f */
+incdir+verilog
verilog/video_pkg.sv
verilog/keyboard_pkg.sv
verilog/vga_timing.sv
verilog/key_locator.sv
verilog/key_painter.sv
verilog/keyboard_display.sv
verification/keyboard_display_assert.sv
verification/keyboard_display_tb.sv

/* Makefile */
# Verilator simulation of the VGA keyboard display

VERILATOR ?= verilator
TOP       ?= keyboard_display_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
